// File: verilog/dram_sim_consts.svh
`ifndef DRAM_SIM_CONSTS_SVH
`define DRAM_SIM_CONSTS_SVH

// Bus and word geometry
`define DRAM_ADDR_W 16
`define DRAM_DATA_W 64

// Start of the memory window on the bus
`define DRAM_BASE 16'h8000

`define DRAM_WORDS 256
`define DRAM_RD_LATENCY 3

// Outstanding write responses
`define B_CNT_DEPTH 4

`endif

// File: verilog/dram_sim_pkg.sv
`include "dram_sim_consts.svh"

package dram_sim_pkg;

    typedef struct packed {
        logic [`DRAM_ADDR_W-1:0] addr;
    } axil_ax_t;

    typedef struct packed {
        logic [`DRAM_DATA_W-1:0] data;
    } axil_w_t;

    typedef struct packed {
        logic [`DRAM_DATA_W-1:0] data;
        logic [1:0]              resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    // Master-driven side of the port
    typedef struct packed {
        axil_ax_t ar;
        logic     ar_valid;
        axil_ax_t aw;
        logic     aw_valid;
        axil_w_t  w;
        logic     w_valid;
        logic     r_ready;
        logic     b_ready;
    } axil_req_t;

    // Slave-driven side of the port
    typedef struct packed {
        logic    ar_ready;
        logic    aw_ready;
        logic    w_ready;
        axil_r_t r;
        logic    r_valid;
        axil_b_t b;
        logic    b_valid;
    } axil_resp_t;

    // Address is already aligned and rebased
    typedef struct packed {
        logic                    we;
        logic [`DRAM_ADDR_W-1:0] addr;
        logic [`DRAM_DATA_W-1:0] wdata;
    } dram_req_t;

endpackage

// File: verilog/axil_dram_frontend.sv
`timescale 1ns/1ps
`include "dram_sim_consts.svh"

module axil_dram_frontend
    import dram_sim_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  axil_req_t               axil_req_i,
    output axil_resp_t              axil_resp_o,
    output dram_req_t               wr_req_o,
    output logic                    wr_valid_o,
    input  logic                    wr_ready_i,
    output dram_req_t               rd_req_o,
    output logic                    rd_valid_o,
    input  logic                    rd_ready_i,
    input  logic [`DRAM_DATA_W-1:0] rd_rsp_data_i,
    input  logic                    rd_rsp_valid_i,
    output logic                    rd_rsp_ready_o
);

    localparam int unsigned ALIGN_SHIFT = $clog2(`DRAM_DATA_W / 8);
    localparam int unsigned B_CNT_W     = $clog2(`B_CNT_DEPTH + 1);

    logic [`DRAM_ADDR_W-1:0] rd_addr;
    logic [`DRAM_ADDR_W-1:0] wr_addr;
    logic [B_CNT_W-1:0]      b_cnt_q;
    logic                    b_full;
    logic                    b_push;
    logic                    b_pop;

    // Drop byte offset, then move into the memory window
    assign rd_addr = ((axil_req_i.ar.addr >> ALIGN_SHIFT) << ALIGN_SHIFT) - `DRAM_BASE;
    assign wr_addr = ((axil_req_i.aw.addr >> ALIGN_SHIFT) << ALIGN_SHIFT) - `DRAM_BASE;

    // AR
    assign rd_req_o = '{
        we:    1'b0,
        addr:  rd_addr,
        wdata: '0
    };
    assign rd_valid_o           = axil_req_i.ar_valid;
    assign axil_resp_o.ar_ready = rd_ready_i;

    // AW and W accepted together
    assign wr_req_o = '{
        we:    1'b1,
        addr:  wr_addr,
        wdata: axil_req_i.w.data
    };
    assign wr_valid_o           = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_full;
    assign axil_resp_o.aw_ready = wr_ready_i & wr_valid_o;
    assign axil_resp_o.w_ready  = wr_ready_i & wr_valid_o;

    // R straight from the model
    assign axil_resp_o.r.data  = rd_rsp_data_i;
    assign axil_resp_o.r.resp  = 2'b00;
    assign axil_resp_o.r_valid = rd_rsp_valid_i;
    assign rd_rsp_ready_o      = axil_req_i.r_ready;

    // B count
    assign b_full  = (b_cnt_q == B_CNT_W'(`B_CNT_DEPTH));
    assign b_push  = wr_valid_o & wr_ready_i;
    assign b_pop   = axil_resp_o.b_valid & axil_req_i.b_ready;

    assign axil_resp_o.b.resp  = 2'b00;
    assign axil_resp_o.b_valid = (b_cnt_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            b_cnt_q <= '0;
        end else begin
            case ({b_push, b_pop})
                2'b10:   b_cnt_q <= b_cnt_q + 1'b1;
                2'b01:   b_cnt_q <= b_cnt_q - 1'b1;
                default: b_cnt_q <= b_cnt_q;
            endcase
        end
    end

    // Write accepted while the count is full would overflow it
    a_b_cnt_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        b_push && !b_pop |-> ##1 b_cnt_q <= B_CNT_W'(`B_CNT_DEPTH)
    );

    a_b_cnt_no_underflow: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        b_pop && !b_push |-> ##1 b_cnt_q < B_CNT_W'(`B_CNT_DEPTH)
    );

endmodule

// File: verilog/dram_req_arbiter.sv
`timescale 1ns/1ps

module dram_req_arbiter
    import dram_sim_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  dram_req_t wr_req_i,
    input  logic      wr_valid_i,
    output logic      wr_ready_o,
    input  dram_req_t rd_req_i,
    input  logic      rd_valid_i,
    output logic      rd_ready_o,
    output dram_req_t mem_req_o,
    output logic      mem_valid_o,
    input  logic      mem_ready_i
);

    // High means the read stream has priority next
    logic prio_rd_q;
    logic lock_q;
    logic lock_rd_q;
    logic sel_rd;
    logic xfer;

    always_comb begin
        if (lock_q) begin
            sel_rd = lock_rd_q;
        end else if (wr_valid_i && rd_valid_i) begin
            sel_rd = prio_rd_q;
        end else begin
            sel_rd = rd_valid_i;
        end
    end

    assign mem_req_o   = sel_rd ? rd_req_i : wr_req_i;
    assign mem_valid_o = sel_rd ? rd_valid_i : wr_valid_i;
    assign wr_ready_o  = ~sel_rd & mem_ready_i;
    assign rd_ready_o  = sel_rd & mem_ready_i;

    assign xfer = mem_valid_o & mem_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_rd_q <= 1'b0;
            lock_q    <= 1'b0;
            lock_rd_q <= 1'b0;
        end else begin
            if (xfer) begin
                prio_rd_q <= ~sel_rd;
            end
            // Hold the grant while the memory stalls
            lock_q    <= mem_valid_o & ~mem_ready_i;
            lock_rd_q <= sel_rd;
        end
    end

    a_mem_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o)
    );

endmodule

// File: verilog/dram_model.sv
`timescale 1ns/1ps
`include "dram_sim_consts.svh"

module dram_model
    import dram_sim_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  dram_req_t               mem_req_i,
    input  logic                    mem_valid_i,
    output logic                    mem_ready_o,
    output logic [`DRAM_DATA_W-1:0] rd_rsp_data_o,
    output logic                    rd_rsp_valid_o,
    input  logic                    rd_rsp_ready_i
);

    localparam int unsigned ALIGN_SHIFT = $clog2(`DRAM_DATA_W / 8);
    localparam int unsigned IDX_W       = $clog2(`DRAM_WORDS);
    localparam int unsigned LAT_W       = $clog2(`DRAM_RD_LATENCY + 1);

    logic [`DRAM_DATA_W-1:0] mem_q [`DRAM_WORDS];
    logic [`DRAM_DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]        word_idx;
    logic [LAT_W-1:0]        lat_cnt_q;
    logic                    busy_q;
    logic                    rsp_valid_q;
    logic                    accept;
    logic                    rd_accept;
    logic                    rsp_pop;

    // Upper address bits wrap around the array
    assign word_idx = mem_req_i.addr[ALIGN_SHIFT +: IDX_W];

    assign mem_ready_o = ~busy_q;
    assign accept      = mem_valid_i & mem_ready_o;
    assign rd_accept   = accept & ~mem_req_i.we;
    assign rsp_pop     = rsp_valid_q & rd_rsp_ready_i;

    assign rd_rsp_data_o  = rdata_q;
    assign rd_rsp_valid_o = rsp_valid_q;

    always_ff @(posedge clk_i) begin
        if (accept && mem_req_i.we) begin
            mem_q[word_idx] <= mem_req_i.wdata;
        end
        if (rd_accept) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    // Countdown to read valid, then wait for the pop
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            lat_cnt_q   <= '0;
        end else if (rd_accept) begin
            busy_q    <= 1'b1;
            lat_cnt_q <= LAT_W'(`DRAM_RD_LATENCY - 1);
        end else if (rsp_pop) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else if (busy_q && !rsp_valid_q) begin
            if (lat_cnt_q == '0) begin
                rsp_valid_q <= 1'b1;
            end else begin
                lat_cnt_q <= lat_cnt_q - 1'b1;
            end
        end
    end

    a_rsp_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_rsp_data_o)
    );

    // One read in flight until its response is taken
    a_no_accept_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rd_accept |=> !mem_ready_o until_with rsp_pop
    );

endmodule

// File: verilog/axil_dram_sim.sv
`timescale 1ns/1ps
`include "dram_sim_consts.svh"

module axil_dram_sim
    import dram_sim_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  axil_req_t  axil_req_i,
    output axil_resp_t axil_resp_o
);

    dram_req_t               wr_req;
    logic                    wr_valid;
    logic                    wr_ready;
    dram_req_t               rd_req;
    logic                    rd_valid;
    logic                    rd_ready;
    dram_req_t               mem_req;
    logic                    mem_valid;
    logic                    mem_ready;
    logic [`DRAM_DATA_W-1:0] rd_rsp_data;
    logic                    rd_rsp_valid;
    logic                    rd_rsp_ready;

    axil_dram_frontend u_frontend (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .axil_req_i     (axil_req_i),
        .axil_resp_o    (axil_resp_o),
        .wr_req_o       (wr_req),
        .wr_valid_o     (wr_valid),
        .wr_ready_i     (wr_ready),
        .rd_req_o       (rd_req),
        .rd_valid_o     (rd_valid),
        .rd_ready_i     (rd_ready),
        .rd_rsp_data_i  (rd_rsp_data),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_ready_o (rd_rsp_ready)
    );

    dram_req_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_req_i    (wr_req),
        .wr_valid_i  (wr_valid),
        .wr_ready_o  (wr_ready),
        .rd_req_i    (rd_req),
        .rd_valid_i  (rd_valid),
        .rd_ready_o  (rd_ready),
        .mem_req_o   (mem_req),
        .mem_valid_o (mem_valid),
        .mem_ready_i (mem_ready)
    );

    dram_model u_model (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mem_req_i      (mem_req),
        .mem_valid_i    (mem_valid),
        .mem_ready_o    (mem_ready),
        .rd_rsp_data_o  (rd_rsp_data),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_ready_i (rd_rsp_ready)
    );

endmodule

// File: tests/tb_axil_dram_sim.sv
`timescale 1ns/1ps
`include "dram_sim_consts.svh"

module tb_axil_dram_sim
    import dram_sim_pkg::*;
();

    localparam time CLK_PERIOD = 40ns;
    localparam int  NUM_TXN    = 56;
    localparam int  WORD_BYTES = `DRAM_DATA_W / 8;

    logic                    clk;
    logic                    rst_n;
    axil_req_t               req;
    axil_resp_t              rsp;
    logic [`DRAM_DATA_W-1:0] ref_mem [int];
    logic [`DRAM_ADDR_W-1:0] t1_addrs [20];
    int                      test_err;
    int                      pass_cnt;
    int                      fail_cnt;

    axil_dram_sim u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .axil_req_i  (req),
        .axil_resp_o (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Each transaction takes at most the read latency plus a few handshake cycles
    initial begin
        #(NUM_TXN * (`DRAM_RD_LATENCY + 10) * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog expired, a handshake never completed");
        $display("TESTS FAILED");
        $finish;
    end

    function automatic int word_index(input logic [`DRAM_ADDR_W-1:0] addr);
        logic [`DRAM_ADDR_W-1:0] off;
        off = addr - `DRAM_BASE;
        return (off / WORD_BYTES) % `DRAM_WORDS;
    endfunction

    task automatic check_r(input string name, input axil_r_t exp, input axil_r_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_b(input string name, input axil_b_t exp, input axil_b_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("error %s expected %0d actual %0d", name, exp, act);
            test_err++;
        end
    endtask

    task automatic fail_msg(input string name, input string what);
        $display("%s: %s", name, what);
        test_err++;
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("test %s ok", name);
            pass_cnt++;
        end else begin
            $display("test %s failed with %0d errors", name, test_err);
            fail_cnt++;
        end
        test_err = 0;
    endtask

    task automatic write_issue(input logic [`DRAM_ADDR_W-1:0] addr,
                               input logic [`DRAM_DATA_W-1:0] data);
        @(posedge clk);
        req.aw.addr  <= addr;
        req.w.data   <= data;
        req.aw_valid <= 1'b1;
        req.w_valid  <= 1'b1;
        do @(negedge clk); while (!(rsp.aw_ready && rsp.w_ready));
        ref_mem[word_index(addr)] = data;
        @(posedge clk);
        req.aw_valid <= 1'b0;
        req.w_valid  <= 1'b0;
    endtask

    task automatic axil_write(input string name, input logic [`DRAM_ADDR_W-1:0] addr,
                              input logic [`DRAM_DATA_W-1:0] data);
        write_issue(addr, data);
        do @(negedge clk); while (!rsp.b_valid);
        check_b(name, '{resp: 2'b00}, rsp.b);
    endtask

    task automatic read_issue(input logic [`DRAM_ADDR_W-1:0] addr);
        @(posedge clk);
        req.ar.addr  <= addr;
        req.ar_valid <= 1'b1;
        do @(negedge clk); while (!rsp.ar_ready);
        @(posedge clk);
        req.ar_valid <= 1'b0;
    endtask

    // Counts rising edges from the AR handshake until R valid
    task automatic r_wait(output axil_r_t r, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!rsp.r_valid);
        r = rsp.r;
    endtask

    task automatic axil_read(input logic [`DRAM_ADDR_W-1:0] addr, output axil_r_t r,
                             output int cycles);
        read_issue(addr);
        r_wait(r, cycles);
    endtask

    task automatic test_write_read();
        axil_r_t r;
        int      cyc;
        foreach (t1_addrs[i]) begin
            t1_addrs[i] = `DRAM_BASE + ($urandom % `DRAM_WORDS) * WORD_BYTES;
            axil_write("write_read", t1_addrs[i], {$urandom, $urandom});
        end
        foreach (t1_addrs[i]) begin
            axil_read(t1_addrs[i], r, cyc);
            check_r("write_read", '{data: ref_mem[word_index(t1_addrs[i])], resp: 2'b00}, r);
        end
        finish_test("write_read");
    endtask

    task automatic test_align();
        axil_r_t r;
        int      cyc;
        axil_write("align", `DRAM_BASE + 16'h0013, 64'h0123_4567_89ab_cdef);
        axil_read(`DRAM_BASE + 16'h0010, r, cyc);
        check_r("align", '{data: 64'h0123_4567_89ab_cdef, resp: 2'b00}, r);
        // One window past the end lands on word zero
        axil_write("align", `DRAM_BASE + `DRAM_WORDS * WORD_BYTES, 64'hfeed_0000_beef_0001);
        axil_read(`DRAM_BASE, r, cyc);
        check_r("align", '{data: 64'hfeed_0000_beef_0001, resp: 2'b00}, r);
        finish_test("align");
    endtask

    task automatic test_latency();
        axil_r_t r;
        int      cyc;
        axil_read(t1_addrs[3], r, cyc);
        check_cycles("latency", `DRAM_RD_LATENCY, cyc);
        finish_test("latency");
    endtask

    task automatic test_b_backpressure();
        int b_seen;
        int accepted;
        bit drained;
        @(posedge clk);
        req.b_ready <= 1'b0;
        for (int i = 0; i < `B_CNT_DEPTH; i++) begin
            write_issue(`DRAM_BASE + 16'h0100 + i * WORD_BYTES, 64'h0b0b_0000 + i);
        end
        @(posedge clk);
        req.aw.addr  <= `DRAM_BASE + 16'h0180;
        req.w.data   <= 64'h0b0b_ffff;
        req.aw_valid <= 1'b1;
        req.w_valid  <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            if (rsp.aw_ready || rsp.w_ready) fail_msg("b_backpressure", "write taken while full");
        end
        @(posedge clk);
        req.b_ready <= 1'b1;
        b_seen   = 0;
        accepted = 0;
        drained  = 0;
        // Count every B beat until the count has drained after the blocked write
        for (int c = 0; c < 40 && !drained; c++) begin
            @(negedge clk);
            if (rsp.b_valid) begin
                b_seen++;
            end else if (accepted) begin
                drained = 1;
            end
            if (rsp.aw_ready && !accepted) begin
                accepted = 1;
                ref_mem[word_index(`DRAM_BASE + 16'h0180)] = 64'h0b0b_ffff;
            end
            @(posedge clk);
            if (accepted) begin
                req.aw_valid <= 1'b0;
                req.w_valid  <= 1'b0;
            end
        end
        if (!accepted) fail_msg("b_backpressure", "blocked write never accepted");
        check_cycles("b_backpressure", `B_CNT_DEPTH + 1, b_seen);
        finish_test("b_backpressure");
    endtask

    task automatic test_r_backpressure();
        axil_r_t r0;
        axil_r_t r1;
        int      cyc;
        @(posedge clk);
        req.r_ready <= 1'b0;
        axil_read(t1_addrs[0], r0, cyc);
        check_r("r_backpressure", '{data: ref_mem[word_index(t1_addrs[0])], resp: 2'b00}, r0);
        @(posedge clk);
        req.ar.addr  <= t1_addrs[1];
        req.ar_valid <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (!rsp.r_valid) fail_msg("r_backpressure", "R valid dropped while R held");
            check_r("r_backpressure", '{data: ref_mem[word_index(t1_addrs[0])], resp: 2'b00},
                    rsp.r);
            if (rsp.ar_ready) fail_msg("r_backpressure", "second read accepted while R held");
        end
        @(posedge clk);
        req.r_ready <= 1'b1;
        do @(negedge clk); while (!rsp.ar_ready);
        @(posedge clk);
        req.ar_valid <= 1'b0;
        r_wait(r1, cyc);
        check_r("r_backpressure", '{data: ref_mem[word_index(t1_addrs[1])], resp: 2'b00}, r1);
        finish_test("r_backpressure");
    endtask

    task automatic mixed_pair(input logic [`DRAM_ADDR_W-1:0] raddr,
                              input logic [`DRAM_ADDR_W-1:0] waddr,
                              input logic [`DRAM_DATA_W-1:0] wdata, input bit want_wr_first);
        axil_r_t exp;
        bit      wdone;
        bit      rdone;
        bit      rgot;
        bit      wr_first;
        wdone    = 0;
        rdone    = 0;
        rgot     = 0;
        wr_first = 0;
        exp      = '0;
        @(posedge clk);
        req.ar.addr  <= raddr;
        req.ar_valid <= 1'b1;
        req.aw.addr  <= waddr;
        req.w.data   <= wdata;
        req.aw_valid <= 1'b1;
        req.w_valid  <= 1'b1;
        while (!(wdone && rgot)) begin
            @(negedge clk);
            if (rsp.aw_ready) begin
                wdone    = 1;
                wr_first = !rdone;
                ref_mem[word_index(waddr)] = wdata;
            end
            if (rsp.ar_ready) begin
                rdone    = 1;
                exp.data = ref_mem[word_index(raddr)];
            end else if (rdone && !rgot && rsp.r_valid) begin
                rgot = 1;
                check_r("mixed", exp, rsp.r);
            end
            @(posedge clk);
            if (wdone) begin
                req.aw_valid <= 1'b0;
                req.w_valid  <= 1'b0;
            end
            if (rdone) req.ar_valid <= 1'b0;
        end
        if (want_wr_first && !wr_first) fail_msg("mixed", "read granted before write after reset");
    endtask

    task automatic test_mixed();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        mixed_pair(t1_addrs[5], t1_addrs[6] + 16'h0800, 64'h6666_0001, 1'b1);
        mixed_pair(t1_addrs[7], t1_addrs[7], 64'h6666_0002, 1'b0);
        finish_test("mixed");
    endtask

    initial begin
        void'($urandom(32'hb5ed_e8ba));
        rst_n    = 1'b0;
        req      = '0;
        test_err = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (2) @(posedge clk);
        rst_n       <= 1'b1;
        req.r_ready <= 1'b1;
        req.b_ready <= 1'b1;
        test_write_read();
        test_align();
        test_latency();
        test_b_backpressure();
        test_r_backpressure();
        test_mixed();
        $display("pass count %0d fail count %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+verilog
verilog/dram_sim_pkg.sv
verilog/axil_dram_frontend.sv
verilog/dram_req_arbiter.sv
verilog/dram_model.sv
verilog/axil_dram_sim.sv
tests/tb_axil_dram_sim.sv
